// File: filelist.f
logic/pinmux_pkg.sv
logic/reg_decode.sv
logic/glbl_reg.sv
logic/gpio_reg.sv
logic/timer_reg.sv
logic/pad_mux.sv
logic/pinmux_top.sv
tests/tb_clk_gen.sv
tests/pinmux_assert.sv
tests/tb_pinmux.sv

// File: Makefile
# Verilator flow for the pin multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_pinmux
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_pinmux.sv
`timescale 1ns/10ps

module tb_pinmux import pinmux_pkg::*; ();

   typedef enum logic [3:0] {
      OP_WR, OP_RD, OP_PAD, OP_TXD, OP_IDLE, OP_IRQ, OP_OUT, OP_OEN, OP_RXD, OP_DONE
   } op_e;

   // One table row
   // Pad doubles as compare mask for pad checks
   typedef struct packed {
      op_e         op;
      logic [8:0]  addr;
      logic [31:0] wdata;
      logic [3:0]  be;
      pad_t        pad;
      logic [31:0] exp;
   } step_t;

   logic        mclk;
   logic        rst_n;
   reg_req_t    req;
   reg_rsp_t    rsp_w;
   logic        irq;
   logic        txd;
   logic        rxd;
   pad_t        pad_in;
   pad_t        dio_out;
   pad_t        dio_oen;
   step_t       steps[$];
   logic [15:0] lfsr;
   int          chk_cnt;
   int          err_cnt;
   string       test_names[5] = '{"gpio byte enables", "gpio edge interrupt",
                                  "timer event", "uart routing", "identity and unmapped"};

   tb_clk_gen u_clk_gen (.clk_o(mclk), .rst_n_o(rst_n));

   pinmux_top uut (
      .mclk             (mclk),
      .rst_n_i          (rst_n),
      .reg_req_i        (req),
      .reg_rsp_o        (rsp_w),
      .irq_o            (irq),
      .uart_txd_i       (txd),
      .uart_rxd_o       (rxd),
      .digital_io_in_i  (pad_in),
      .digital_io_out_o (dio_out),
      .digital_io_oen_o (dio_oen)
   );

   // ------------------------------------------------
   // Random source
   // ------------------------------------------------
   // Galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) begin
         s = s ^ 16'hB400;
      end
      return s;
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] w);
      w = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         w    = {w[30:0], lfsr[0]};
      end
   endtask

   // Byte lanes with be set take the new data
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            old_w[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return old_w;
   endfunction

   function automatic logic [8:0] reg_addr(input logic [2:0] blk, input logic [3:0] word);
      reg_addr_t a;
      a.blk      = blk;
      a.word     = word;
      a.byte_off = 2'b00;
      return a;
   endfunction

   // ------------------------------------------------
   // Table building
   // ------------------------------------------------
   task automatic add_step(input op_e op, input logic [8:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input pad_t pad, input logic [31:0] exp);
      step_t s;
      s.op    = op;
      s.addr  = addr;
      s.wdata = wdata;
      s.be    = be;
      s.pad   = pad;
      s.exp   = exp;
      steps.push_back(s);
   endtask

   task automatic add_write(input logic [8:0] addr, input logic [31:0] d, input logic [3:0] be);
      add_step(OP_WR, addr, d, be, '0, '0);
   endtask

   task automatic add_read(input logic [8:0] addr, input logic [31:0] exp);
      add_step(OP_RD, addr, '0, 4'hF, '0, exp);
   endtask

   task automatic build_table();
      logic [31:0] d0;
      logic [31:0] d1;
      logic [31:0] o0;
      logic [31:0] o1;
      logic [31:0] r;
      logic [31:0] dir_w;
      logic [31:0] out_w;
      pad_t        dir_exp;
      pad_t        out_exp;
      pad_t        pin_bit;
      int          pin;
      rand_bits(32, d0);
      rand_bits(32, d1);
      rand_bits(32, o0);
      rand_bits(32, o1);
      // Partial writes checked against the byte lane rule
      add_write(reg_addr(SEL_GPIO, GPIO_DIR), d0, 4'b0001);
      add_write(reg_addr(SEL_GPIO, GPIO_DIR), d1, 4'b1110);
      dir_w   = merge_bytes(merge_bytes('0, d0, 4'b0001), d1, 4'b1110);
      dir_exp = dir_w[15:0];
      add_read(reg_addr(SEL_GPIO, GPIO_DIR), {16'h0, dir_exp});
      add_write(reg_addr(SEL_GPIO, GPIO_OUT), o0, 4'b0010);
      add_write(reg_addr(SEL_GPIO, GPIO_OUT), o1, 4'b1101);
      out_w   = merge_bytes(merge_bytes('0, o0, 4'b0010), o1, 4'b1101);
      out_exp = out_w[15:0];
      add_read(reg_addr(SEL_GPIO, GPIO_OUT), {16'h0, out_exp});
      add_step(OP_OUT, '0, '0, '0, dir_exp, {16'h0, out_exp & dir_exp});
      add_step(OP_OEN, '0, '0, '0, 16'hFFFF, {16'h0, ~dir_exp});
      add_step(OP_DONE, '0, '0, '0, '0, '0);
      // Edge interrupt on a random pin above the UART pins
      rand_bits(4, r);
      pin          = 2 + (r % 14);
      pin_bit      = '0;
      pin_bit[pin] = 1'b1;
      add_write(reg_addr(SEL_GPIO, GPIO_INTR_EN), {16'h0, pin_bit}, 4'b0011);
      add_write(reg_addr(SEL_GLBL, GLBL_INTR_MASK), 32'h2, 4'b0001);
      add_step(OP_PAD, '0, '0, '0, pin_bit, '0);
      // Status sampled on the 4th edge after the pad change
      add_step(OP_IDLE, '0, 32'd2, '0, '0, '0);
      add_read(reg_addr(SEL_GPIO, GPIO_INTR_STAT), {16'h0, pin_bit});
      add_read(reg_addr(SEL_GPIO, GPIO_IN), {16'h0, pin_bit});
      add_step(OP_IRQ, '0, 32'd10, '0, '0, 32'h1);
      add_write(reg_addr(SEL_GPIO, GPIO_INTR_STAT), {16'h0, pin_bit}, 4'b0011);
      add_step(OP_IRQ, '0, 32'd10, '0, '0, 32'h0);
      add_read(reg_addr(SEL_GPIO, GPIO_INTR_STAT), 32'h0);
      add_step(OP_DONE, '0, '0, '0, '0, '0);
      // Period (2+1)*(3+1) = 12 cycles
      add_write(reg_addr(SEL_TIMER, TMR_PRESCALE), 32'd2, 4'hF);
      add_write(reg_addr(SEL_TIMER, TMR_COMPARE), 32'd3, 4'hF);
      add_write(reg_addr(SEL_GLBL, GLBL_INTR_MASK), 32'h1, 4'b0001);
      add_write(reg_addr(SEL_TIMER, TMR_CTRL), 32'h1, 4'b0001);
      add_step(OP_IRQ, '0, 32'd20, '0, '0, 32'h1);
      add_read(reg_addr(SEL_GLBL, GLBL_INTR_STAT), 32'h1);
      add_write(reg_addr(SEL_TIMER, TMR_CTRL), 32'h0, 4'b0001);
      add_write(reg_addr(SEL_GLBL, GLBL_INTR_STAT), 32'h1, 4'b0001);
      add_read(reg_addr(SEL_GLBL, GLBL_INTR_STAT), 32'h0);
      add_step(OP_IRQ, '0, 32'd10, '0, '0, 32'h0);
      add_step(OP_DONE, '0, '0, '0, '0, '0);
      // UART owns pins 0 and 1
      add_write(reg_addr(SEL_GLBL, GLBL_MULTI_FUNC), 32'h1, 4'b0001);
      add_step(OP_TXD, '0, 32'h0, '0, '0, '0);
      add_step(OP_OUT, '0, '0, '0, 16'h0002, 32'h0);
      add_step(OP_TXD, '0, 32'h1, '0, '0, '0);
      add_step(OP_OUT, '0, '0, '0, 16'h0002, 32'h2);
      add_step(OP_OEN, '0, '0, '0, 16'h0003, 32'h1);
      add_step(OP_PAD, '0, '0, '0, pin_bit | 16'h0001, '0);
      add_step(OP_RXD, '0, '0, '0, '0, 32'h1);
      add_step(OP_PAD, '0, '0, '0, pin_bit, '0);
      add_step(OP_RXD, '0, '0, '0, '0, 32'h0);
      // Back to GPIO with rx idling high
      add_write(reg_addr(SEL_GLBL, GLBL_MULTI_FUNC), 32'h0, 4'b0001);
      add_step(OP_RXD, '0, '0, '0, '0, 32'h1);
      add_step(OP_OUT, '0, '0, '0, 16'h0003, {30'h0, out_exp[1:0]});
      add_step(OP_OEN, '0, '0, '0, 16'h0003, {30'h0, ~dir_exp[1:0]});
      add_step(OP_DONE, '0, '0, '0, '0, '0);
      // Identity word and holes in the map
      rand_bits(4, r);
      add_read(reg_addr(SEL_GLBL, GLBL_CHIP_ID), CHIP_ID_VAL);
      add_read(reg_addr(3'd2, r[3:0]), 32'h0);
      add_read(reg_addr(3'd4, 4'd0), 32'h0);
      add_step(OP_DONE, '0, '0, '0, '0, '0);
   endtask

   // ------------------------------------------------
   // Bus and waits
   // ------------------------------------------------
   task automatic bus_access(input logic wr, input logic [8:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, output reg_rsp_t rsp, output logic ok);
      reg_req_t r;
      int       n;
      r.cs        = 1'b1;
      r.wr        = wr;
      r.addr.flat = addr;
      r.wdata     = wdata;
      r.be        = be;
      ok          = 1'b0;
      n           = 0;
      @(posedge mclk);
      req <= r;
      // Ack sampled mid-cycle
      while (!ok && n < 8) begin
         @(negedge mclk);
         ok = rsp_w.ack;
         n++;
      end
      rsp = rsp_w;
      @(posedge mclk);
      req.cs <= 1'b0;
   endtask

   task automatic wait_irq(input logic level, input int limit, output logic ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge mclk);
         ok = (irq === level);
         n++;
      end
   endtask

   // ------------------------------------------------
   // Compare tasks
   // ------------------------------------------------
   task automatic check_rsp(input string name, input reg_rsp_t got, input logic [31:0] exp);
      chk_cnt++;
      if (got.rdata !== exp) begin
         $display("Fail at %0t: %s got %h, expected %h", $time, name, got.rdata, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pad(input string name, input pad_t got, input pad_t exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // ------------------------------------------------
   // Main sequence
   // ------------------------------------------------
   initial begin
      step_t    s;
      reg_rsp_t rsp;
      logic     ok;
      logic     timed_out;
      int       test_idx;
      int       test_err0;
      int       fired;
      int       n;
      req       = '0;
      pad_in    = '0;
      txd       = 1'b1;
      lfsr      = 16'd30;
      chk_cnt   = 0;
      err_cnt   = 0;
      test_idx  = 0;
      test_err0 = 0;
      timed_out = 1'b0;
      build_table();
      n = 0;
      while (rst_n !== 1'b1 && n < 20) begin
         @(posedge mclk);
         n++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was never released");
         timed_out = 1'b1;
      end
      for (int i = 0; i < steps.size() && !timed_out; i++) begin
         s  = steps[i];
         ok = 1'b1;
         case (s.op)
            OP_WR: bus_access(1'b1, s.addr, s.wdata, s.be, rsp, ok);
            OP_RD: begin
               bus_access(1'b0, s.addr, '0, 4'hF, rsp, ok);
               if (ok) begin
                  check_rsp($sformatf("reg_rsp_o.rdata[%h]", s.addr), rsp, s.exp);
               end
            end
            OP_PAD: begin
               @(posedge mclk);
               pad_in <= s.pad;
            end
            OP_TXD: begin
               @(posedge mclk);
               txd <= s.wdata[0];
            end
            OP_IDLE: repeat (s.wdata) @(posedge mclk);
            OP_IRQ: wait_irq(s.exp[0], s.wdata, ok);
            OP_OUT: begin
               @(negedge mclk);
               check_pad("digital_io_out_o", dio_out & s.pad, s.exp[15:0]);
            end
            OP_OEN: begin
               @(negedge mclk);
               check_pad("digital_io_oen_o", dio_oen & s.pad, s.exp[15:0]);
            end
            OP_RXD: begin
               @(negedge mclk);
               check_level("uart_rxd_o", rxd, s.exp[0]);
            end
            default: begin
               $display("Test %0d (%s) done with %0d errors", test_idx + 1,
                        test_names[test_idx], err_cnt - test_err0);
               test_err0 = err_cnt;
               test_idx++;
            end
         endcase
         if (!ok) begin
            $display("Timeout in test %0d (%s) at table row %0d", test_idx + 1,
                     test_names[test_idx], i);
            timed_out = 1'b1;
         end
      end
      fired = uut.u_pinmux_assert.fire_cnt;
      $display("Checks run %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt, fired);
      if (err_cnt == 0 && fired == 0 && !timed_out) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: tests/pinmux_assert.sv
`timescale 1ns/10ps

module pinmux_assert import pinmux_pkg::*; (
   input logic     mclk,
   input logic     rst_n_i,
   input reg_req_t req_i,
   input reg_rsp_t rsp_i,
   input logic     uart_en_i,
   input pad_t     oen_i
);

   int fire_cnt = 0;

   // ------------------------------------------------
   // Bus rules
   // ------------------------------------------------
   // Ack is a single-cycle pulse
   ack_single: assert property (@(posedge mclk) disable iff (!rst_n_i)
      rsp_i.ack |=> !rsp_i.ack)
   else begin
      $error("ack high for two cycles in a row");
      fire_cnt++;
   end

   // No ack without a request the cycle before
   ack_after_cs: assert property (@(posedge mclk) disable iff (!rst_n_i)
      rsp_i.ack |-> $past(req_i.cs))
   else begin
      $error("ack without chip select in the previous cycle");
      fire_cnt++;
   end

   // RX pin stays an input while UART owns it
   rx_pin_input: assert property (@(posedge mclk) disable iff (!rst_n_i)
      uart_en_i |-> oen_i[UART_RX_PIN])
   else begin
      $error("pin 0 output enabled while UART is enabled");
      fire_cnt++;
   end

endmodule

bind pinmux_top pinmux_assert u_pinmux_assert (
   .mclk      (mclk),
   .rst_n_i   (rst_n_i),
   .req_i     (reg_req_i),
   .rsp_i     (reg_rsp_o),
   .uart_en_i (uart_en),
   .oen_i     (digital_io_oen_o)
);

// File: tests/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   // 20 ns period
   always #10 clk_o = ~clk_o;

   initial begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      // Reset held low for 5 rising edges
      repeat (5) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// File: logic/pinmux_top.sv
`timescale 1ns/10ps

module pinmux_top import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     rst_n_i,
   // Register bus
   input  reg_req_t reg_req_i,
   output reg_rsp_t reg_rsp_o,
   output logic     irq_o,
   // UART
   input  logic     uart_txd_i,
   output logic     uart_rxd_o,
   // Pads
   input  pad_t     digital_io_in_i,
   output pad_t     digital_io_out_o,
   output pad_t     digital_io_oen_o
);

   reg_req_t glbl_req;
   reg_req_t gpio_req;
   reg_req_t tmr_req;
   reg_rsp_t glbl_rsp;
   reg_rsp_t gpio_rsp;
   reg_rsp_t tmr_rsp;
   logic     uart_en;
   logic     timer_evt;
   logic     gpio_intr;
   pad_t     gpio_dir;
   pad_t     gpio_out;
   pad_t     pad_in;

   // ------------------------------------------------
   // Bus decode
   // ------------------------------------------------
   reg_decode u_reg_decode (
      .mclk       (mclk),
      .rst_n_i    (rst_n_i),
      .req_i      (reg_req_i),
      .rsp_o      (reg_rsp_o),
      .glbl_req_o (glbl_req),
      .gpio_req_o (gpio_req),
      .tmr_req_o  (tmr_req),
      .glbl_rsp_i (glbl_rsp),
      .gpio_rsp_i (gpio_rsp),
      .tmr_rsp_i  (tmr_rsp)
   );

   // ------------------------------------------------
   // Register blocks
   // ------------------------------------------------
   glbl_reg u_glbl_reg (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .req_i       (glbl_req),
      .rsp_o       (glbl_rsp),
      .timer_evt_i (timer_evt),
      .gpio_intr_i (gpio_intr),
      .uart_en_o   (uart_en),
      .irq_o       (irq_o)
   );

   gpio_reg u_gpio_reg (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .req_i       (gpio_req),
      .rsp_o       (gpio_rsp),
      .pad_in_i    (pad_in),
      .gpio_dir_o  (gpio_dir),
      .gpio_out_o  (gpio_out),
      .gpio_intr_o (gpio_intr)
   );

   timer_reg u_timer_reg (
      .mclk        (mclk),
      .rst_n_i     (rst_n_i),
      .req_i       (tmr_req),
      .rsp_o       (tmr_rsp),
      .timer_evt_o (timer_evt)
   );

   // Pad side
   pad_mux u_pad_mux (
      .uart_en_i        (uart_en),
      .gpio_dir_i       (gpio_dir),
      .gpio_out_i       (gpio_out),
      .uart_txd_i       (uart_txd_i),
      .uart_rxd_o       (uart_rxd_o),
      .digital_io_in_i  (digital_io_in_i),
      .digital_io_out_o (digital_io_out_o),
      .digital_io_oen_o (digital_io_oen_o),
      .pad_in_o         (pad_in)
   );

endmodule

// File: logic/pad_mux.sv
`timescale 1ns/10ps

module pad_mux import pinmux_pkg::*; (
   input  logic uart_en_i,
   input  pad_t gpio_dir_i,
   input  pad_t gpio_out_i,
   input  logic uart_txd_i,
   output logic uart_rxd_o,
   input  pad_t digital_io_in_i,
   output pad_t digital_io_out_o,
   output pad_t digital_io_oen_o,
   output pad_t pad_in_o
);

   always_comb begin
      // GPIO default, oen active low so dir 1 drives
      digital_io_out_o = gpio_out_i;
      digital_io_oen_o = ~gpio_dir_i;
      uart_rxd_o       = 1'b1;
      if (uart_en_i) begin
         // TX pin always driven
         digital_io_out_o[UART_TX_PIN] = uart_txd_i;
         digital_io_oen_o[UART_TX_PIN] = 1'b0;
         // RX pin forced to input
         digital_io_oen_o[UART_RX_PIN] = 1'b1;
         uart_rxd_o                    = digital_io_in_i[UART_RX_PIN];
      end
   end

   // Raw pad inputs to GPIO, synchronised there
   assign pad_in_o = digital_io_in_i;

endmodule

// File: logic/timer_reg.sv
`timescale 1ns/10ps

module timer_reg import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     rst_n_i,
   input  reg_req_t req_i,
   output reg_rsp_t rsp_o,
   output logic     timer_evt_o
);

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              acc_start;
   logic              wr_en;
   logic [3:0]        word;
   logic [DATA_W-1:0] wmask;
   logic [DATA_W-1:0] wbits;
   logic              tmr_en;
   logic [TMR_W-1:0]  prescale_q;
   logic [TMR_W-1:0]  compare_q;
   logic [TMR_W-1:0]  pre_cnt;
   logic [TMR_W-1:0]  cnt;
   logic              tick;
   logic [DATA_W-1:0] rd_word;

   assign acc_start = req_i.cs && !ack_q;
   assign wr_en     = acc_start && req_i.wr;
   assign word      = req_i.addr.f.word;
   assign wmask     = be_mask(req_i.be);
   assign wbits     = req_i.wdata & wmask;

   // Prescaler wrap, >= guards against a lowered limit
   assign tick = (pre_cnt >= prescale_q);

   // ------------------------------------------------
   // Config registers
   // ------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q      <= 1'b0;
         tmr_en     <= 1'b0;
         prescale_q <= '0;
         compare_q  <= '0;
      end else begin
         ack_q <= acc_start;
         if (wr_en && word == TMR_CTRL && req_i.be[0]) begin
            tmr_en <= req_i.wdata[0];
         end
         if (wr_en && word == TMR_PRESCALE) begin
            prescale_q <= (prescale_q & ~wmask[TMR_W-1:0]) | wbits[TMR_W-1:0];
         end
         if (wr_en && word == TMR_COMPARE) begin
            compare_q <= (compare_q & ~wmask[TMR_W-1:0]) | wbits[TMR_W-1:0];
         end
      end
   end

   // Period is (prescale+1)*(compare+1) cycles
   always_ff @(posedge mclk) begin
      if (!rst_n_i || !tmr_en) begin
         pre_cnt     <= '0;
         cnt         <= '0;
         timer_evt_o <= 1'b0;
      end else if (tick) begin
         pre_cnt <= '0;
         if (cnt >= compare_q) begin
            cnt         <= '0;
            timer_evt_o <= 1'b1;
         end else begin
            cnt         <= cnt + 1'b1;
            timer_evt_o <= 1'b0;
         end
      end else begin
         pre_cnt     <= pre_cnt + 1'b1;
         timer_evt_o <= 1'b0;
      end
   end

   always_comb begin
      case (word)
         TMR_CTRL:     rd_word = DATA_W'(tmr_en);
         TMR_PRESCALE: rd_word = DATA_W'(prescale_q);
         TMR_COMPARE:  rd_word = DATA_W'(compare_q);
         TMR_COUNT:    rd_word = DATA_W'(cnt);
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge mclk) begin
      if (acc_start) begin
         rdata_q <= rd_word;
      end
   end

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.ack   = ack_q;

endmodule

// File: logic/gpio_reg.sv
`timescale 1ns/10ps

module gpio_reg import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     rst_n_i,
   input  reg_req_t req_i,
   output reg_rsp_t rsp_o,
   input  pad_t     pad_in_i,
   output pad_t     gpio_dir_o,
   output pad_t     gpio_out_o,
   output logic     gpio_intr_o
);

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              acc_start;
   logic              wr_en;
   logic [3:0]        word;
   logic [DATA_W-1:0] wmask;
   logic [DATA_W-1:0] wbits;
   pad_t              pmask;
   pad_t              pbits;
   pad_t              dir_q;
   pad_t              out_q;
   pad_t              intr_en_q;
   pad_t              intr_stat_q;
   pad_t              sync_ff1;
   pad_t              sync_ff2;
   pad_t              prev_in;
   pad_t              rise;
   logic [DATA_W-1:0] rd_word;

   assign acc_start = req_i.cs && !ack_q;
   assign wr_en     = acc_start && req_i.wr;
   assign word      = req_i.addr.f.word;
   assign wmask     = be_mask(req_i.be);
   assign wbits     = req_i.wdata & wmask;
   // Pads occupy the low bytes of the word
   assign pmask     = wmask[PAD_W-1:0];
   assign pbits     = wbits[PAD_W-1:0];

   // Edges seen on the synchronised input, gated by enable
   assign rise = sync_ff2 & ~prev_in & intr_en_q;

   // ------------------------------------------------
   // Input synchroniser and edge history
   // ------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         sync_ff1 <= '0;
         sync_ff2 <= '0;
         prev_in  <= '0;
      end else begin
         sync_ff1 <= pad_in_i;
         sync_ff2 <= sync_ff1;
         prev_in  <= sync_ff2;
      end
   end

   // ------------------------------------------------
   // Control registers
   // ------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q       <= 1'b0;
         dir_q       <= '0;
         out_q       <= '0;
         intr_en_q   <= '0;
         intr_stat_q <= '0;
      end else begin
         ack_q <= acc_start;
         if (wr_en && word == GPIO_DIR) begin
            dir_q <= (dir_q & ~pmask) | pbits;
         end
         if (wr_en && word == GPIO_OUT) begin
            out_q <= (out_q & ~pmask) | pbits;
         end
         if (wr_en && word == GPIO_INTR_EN) begin
            intr_en_q <= (intr_en_q & ~pmask) | pbits;
         end
         // Set by edge, cleared by writing 1
         if (wr_en && word == GPIO_INTR_STAT) begin
            intr_stat_q <= (intr_stat_q & ~pbits) | rise;
         end else begin
            intr_stat_q <= intr_stat_q | rise;
         end
      end
   end

   always_comb begin
      case (word)
         GPIO_DIR:       rd_word = DATA_W'(dir_q);
         GPIO_OUT:       rd_word = DATA_W'(out_q);
         GPIO_IN:        rd_word = DATA_W'(sync_ff2);
         GPIO_INTR_EN:   rd_word = DATA_W'(intr_en_q);
         GPIO_INTR_STAT: rd_word = DATA_W'(intr_stat_q);
         default:        rd_word = '0;
      endcase
   end

   always_ff @(posedge mclk) begin
      if (acc_start) begin
         rdata_q <= rd_word;
      end
   end

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.ack   = ack_q;
   assign gpio_dir_o  = dir_q;
   assign gpio_out_o  = out_q;
   // Level interrupt, any pending pin
   assign gpio_intr_o = |intr_stat_q;

endmodule

// File: logic/glbl_reg.sv
`timescale 1ns/10ps

module glbl_reg import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     rst_n_i,
   input  reg_req_t req_i,
   output reg_rsp_t rsp_o,
   input  logic     timer_evt_i,
   input  logic     gpio_intr_i,
   output logic     uart_en_o,
   output logic     irq_o
);

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              acc_start;
   logic              wr_en;
   logic [3:0]        word;
   logic [DATA_W-1:0] wmask;
   logic [DATA_W-1:0] wbits;
   logic [DATA_W-1:0] intr_mask;
   logic [DATA_W-1:0] multi_func;
   logic              timer_stat;
   logic [1:0]        intr_stat;
   logic [DATA_W-1:0] rd_word;

   // Access starts on first edge with cs high and no ack
   assign acc_start = req_i.cs && !ack_q;
   assign wr_en     = acc_start && req_i.wr;
   assign word      = req_i.addr.f.word;
   assign wmask     = be_mask(req_i.be);
   assign wbits     = req_i.wdata & wmask;

   // Sticky timer bit plus live GPIO level
   always_comb begin
      intr_stat                 = '0;
      intr_stat[INTR_TIMER_BIT] = timer_stat;
      intr_stat[INTR_GPIO_BIT]  = gpio_intr_i;
   end

   // ------------------------------------------------
   // Control registers
   // ------------------------------------------------
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         ack_q      <= 1'b0;
         intr_mask  <= '0;
         multi_func <= '0;
         timer_stat <= 1'b0;
         irq_o      <= 1'b0;
      end else begin
         ack_q <= acc_start;
         if (wr_en && word == GLBL_INTR_MASK) begin
            intr_mask <= (intr_mask & ~wmask) | wbits;
         end
         if (wr_en && word == GLBL_MULTI_FUNC) begin
            multi_func <= (multi_func & ~wmask) | wbits;
         end
         // New event wins over write-1-to-clear
         if (timer_evt_i) begin
            timer_stat <= 1'b1;
         end else if (wr_en && word == GLBL_INTR_STAT && wbits[INTR_TIMER_BIT]) begin
            timer_stat <= 1'b0;
         end
         irq_o <= |(intr_stat & intr_mask[1:0]);
      end
   end

   // Read mux
   always_comb begin
      case (word)
         GLBL_CHIP_ID:    rd_word = CHIP_ID_VAL;
         GLBL_INTR_MASK:  rd_word = intr_mask;
         GLBL_INTR_STAT:  rd_word = DATA_W'(intr_stat);
         GLBL_MULTI_FUNC: rd_word = multi_func;
         default:         rd_word = '0;
      endcase
   end

   // Read data captured with the ack
   always_ff @(posedge mclk) begin
      if (acc_start) begin
         rdata_q <= rd_word;
      end
   end

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.ack   = ack_q;
   // UART owns pins 0 and 1 when bit 0 is set
   assign uart_en_o   = multi_func[0];

endmodule

// File: logic/reg_decode.sv
`timescale 1ns/10ps

module reg_decode import pinmux_pkg::*; (
   input  logic     mclk,
   input  logic     rst_n_i,
   // Host side
   input  reg_req_t req_i,
   output reg_rsp_t rsp_o,
   // Block side requests
   output reg_req_t glbl_req_o,
   output reg_req_t gpio_req_o,
   output reg_req_t tmr_req_o,
   // Block side responses
   input  reg_rsp_t glbl_rsp_i,
   input  reg_rsp_t gpio_rsp_i,
   input  reg_rsp_t tmr_rsp_i
);

   logic [2:0] blk_sel;
   logic       blk_mapped;
   logic       unmap_cs;
   logic       unmap_ack;

   // Block code from the top address bits
   assign blk_sel    = req_i.addr.f.blk;
   assign blk_mapped = (blk_sel == SEL_GLBL) || (blk_sel == SEL_GPIO) ||
                       (blk_sel == SEL_TIMER);
   assign unmap_cs   = req_i.cs && !blk_mapped;

   // ------------------------------------------------
   // Request steering
   // ------------------------------------------------
   always_comb begin
      glbl_req_o    = req_i;
      gpio_req_o    = req_i;
      tmr_req_o     = req_i;
      // Only the addressed block sees chip select
      glbl_req_o.cs = req_i.cs && (blk_sel == SEL_GLBL);
      gpio_req_o.cs = req_i.cs && (blk_sel == SEL_GPIO);
      tmr_req_o.cs  = req_i.cs && (blk_sel == SEL_TIMER);
   end

   // Local ack for holes in the map, keeps the host from hanging
   always_ff @(posedge mclk) begin
      if (!rst_n_i) begin
         unmap_ack <= 1'b0;
      end else begin
         unmap_ack <= unmap_cs && !unmap_ack;
      end
   end

   // ------------------------------------------------
   // Response return
   // ------------------------------------------------
   always_comb begin
      case (blk_sel)
         SEL_GLBL:  rsp_o = glbl_rsp_i;
         SEL_GPIO:  rsp_o = gpio_rsp_i;
         SEL_TIMER: rsp_o = tmr_rsp_i;
         default: begin
            // Unmapped reads as zero
            rsp_o.rdata = '0;
            rsp_o.ack   = unmap_ack;
         end
      endcase
   end

endmodule

// File: logic/pinmux_pkg.sv
package pinmux_pkg;

   // ------------------------------------------------
   // Widths
   // ------------------------------------------------
   localparam int PAD_W  = 16;
   localparam int DATA_W = 32;
   localparam int ADDR_W = 9;
   localparam int BE_W   = 4;
   localparam int TMR_W  = 16;

   // Block codes, address bits 8:6
   localparam logic [2:0] SEL_GLBL  = 3'd0;
   localparam logic [2:0] SEL_GPIO  = 3'd1;
   localparam logic [2:0] SEL_TIMER = 3'd3;

   // ------------------------------------------------
   // Word offsets per block
   // ------------------------------------------------
   localparam logic [3:0] GLBL_CHIP_ID    = 4'd0;
   localparam logic [3:0] GLBL_INTR_MASK  = 4'd1;
   localparam logic [3:0] GLBL_INTR_STAT  = 4'd2;
   localparam logic [3:0] GLBL_MULTI_FUNC = 4'd3;

   localparam logic [3:0] GPIO_DIR       = 4'd0;
   localparam logic [3:0] GPIO_OUT       = 4'd1;
   localparam logic [3:0] GPIO_IN        = 4'd2;
   localparam logic [3:0] GPIO_INTR_EN   = 4'd3;
   localparam logic [3:0] GPIO_INTR_STAT = 4'd4;

   localparam logic [3:0] TMR_CTRL     = 4'd0;
   localparam logic [3:0] TMR_PRESCALE = 4'd1;
   localparam logic [3:0] TMR_COMPARE  = 4'd2;
   localparam logic [3:0] TMR_COUNT    = 4'd3;

   localparam logic [DATA_W-1:0] CHIP_ID_VAL = 32'h504D_0116;

   // Pins shared with the UART
   localparam int UART_RX_PIN = 0;
   localparam int UART_TX_PIN = 1;

   // Interrupt status bit positions
   localparam int INTR_TIMER_BIT = 0;
   localparam int INTR_GPIO_BIT  = 1;

   // ------------------------------------------------
   // Bus types
   // ------------------------------------------------
   typedef struct packed {
      logic [2:0] blk;
      logic [3:0] word;
      logic [1:0] byte_off;
   } reg_addr_t;

   // Same address seen flat or split into fields
   typedef union packed {
      logic [ADDR_W-1:0] flat;
      reg_addr_t         f;
   } reg_addr_u;

   typedef struct packed {
      logic              cs;
      logic              wr;
      reg_addr_u         addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ack;
   } reg_rsp_t;

   typedef logic [PAD_W-1:0] pad_t;

   // Expand byte enables into a bit mask
   function automatic logic [DATA_W-1:0] be_mask(input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] m;
      m = '0;
      for (int i = 0; i < BE_W; i++) begin
         m[i*8 +: 8] = {8{be[i]}};
      end
      return m;
   endfunction

endpackage
